//--- hw/memPkg.sv
`default_nettype none

package memPkg;

    // ====================
    // Sizes and timing
    // ====================

    localparam int MEM_BYTES   = 1024;           // Data memory size in bytes.
    localparam int MEM_LATENCY = 10;             // Request to response, in cycles.
    localparam int CACHE_LINES = 16;             // Direct-mapped load cache entries.
    localparam int APB_ADDR_W  = 12;             // Width of the APB address bus.

    localparam logic [3:0] STRB_BYTE = 4'b0001;  // Strobe of a byte store.
    localparam logic [3:0] STRB_HALF = 4'b0011;  // Strobe of a halfword store.

    // ====================
    // Types
    // ====================

    typedef logic [$clog2(MEM_BYTES)-1:0]   memAddrT;
    typedef logic [15:0]                    halfT;
    typedef logic [31:0]                    busWordT;
    typedef logic [$clog2(CACHE_LINES)-1:0] cacheIdxT;

    // One memory access, used between port, cache and memory.
    typedef struct packed {
        logic    valid;
        logic    isWrite;
        logic    isByte;     // Only meaningful for stores.
        memAddrT addr;
        halfT    data;       // Store data; the high byte is unused by byte stores.
    } memReqT;

    // Load data, or zero for the completion of a store.
    typedef struct packed {
        logic valid;
        halfT data;
    } memRspT;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } portStateT;

endpackage

`default_nettype wire

//--- hw/apbMemPort.sv
`timescale 1ns/1ps
`default_nettype none

module apbMemPort
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  busWordT               pwdata,
    input  logic [3:0]            pstrb,
    output busWordT               prdata,
    output logic                  pready,
    output logic                  pslverr,
    output memReqT                portReq,
    input  memRspT                portRsp
);

    portStateT state;
    portStateT nextState;
    logic      access;
    logic      addrOk;
    logic      strbOk;
    logic      goodXfer;
    logic      badXfer;

    // ====================
    // Transfer checks
    // ====================

    assign access   = psel && penable && (state == IDLE);  // First access cycle only.
    assign addrOk   = paddr < APB_ADDR_W'(MEM_BYTES);
    assign strbOk   = !pwrite || (pstrb == STRB_BYTE) || (pstrb == STRB_HALF);
    assign goodXfer = access && addrOk && strbOk;
    assign badXfer  = access && !(addrOk && strbOk);

    // A bad transfer finishes in its first access cycle and never leaves IDLE.
    assign pready  = (state == DONE) || badXfer;
    assign pslverr = badXfer;

    always_comb begin
        portReq.valid   = goodXfer;
        portReq.isWrite = pwrite;
        portReq.isByte  = pwrite && (pstrb == STRB_BYTE);
        portReq.addr    = memAddrT'(paddr);             // Range already checked above.
        portReq.data    = halfT'(pwdata);
    end

    // ====================
    // Port FSM
    // ====================

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (goodXfer) nextState = WAIT;
            WAIT:    if (portRsp.valid) nextState = DONE;
            DONE:    nextState = IDLE;                  // The master sees pready here.
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= IDLE;
            prdata <= '0;
        end else begin
            state <= nextState;
            if (state == WAIT && portRsp.valid) begin
                prdata <= {16'b0, portRsp.data};        // Loads are zero-extended.
            end
        end
    end

    // A response outside WAIT would be dropped, so the cache may only answer a request in flight.
    assert property (@(posedge clk) disable iff (!rstn) portRsp.valid |-> state == WAIT);

endmodule

`default_nettype wire

//--- hw/loadCache.sv
`timescale 1ns/1ps
`default_nettype none

module loadCache
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  memReqT portReq,
    output memRspT portRsp,
    output memReqT memReq,
    input  memRspT memRsp
);

    logic [CACHE_LINES-1:0] lineValid;
    memAddrT                lineAddr [CACHE_LINES];  // Full address serves as the tag.
    halfT                   lineData [CACHE_LINES];

    memReqT   reqQ;          // Request from the port, held for the lookup cycle.
    logic     pending;       // A request is out at the data memory.
    logic     pendLoad;
    memAddrT  pendAddr;

    logic     isLoad;
    logic     isStore;
    logic     hit;
    cacheIdxT reqIdx;
    cacheIdxT belowIdx;
    cacheIdxT aboveIdx;
    cacheIdxT fillIdx;
    memAddrT  belowAddr;
    memAddrT  aboveAddr;

    // ====================
    // Lookup
    // ====================

    assign isLoad    = reqQ.valid && !reqQ.isWrite;
    assign isStore   = reqQ.valid && reqQ.isWrite;
    assign belowAddr = reqQ.addr - memAddrT'(1);    // Wraps like the memory does.
    assign aboveAddr = reqQ.addr + memAddrT'(1);
    assign reqIdx    = cacheIdxT'(reqQ.addr);
    assign belowIdx  = cacheIdxT'(belowAddr);
    assign aboveIdx  = cacheIdxT'(aboveAddr);
    assign fillIdx   = cacheIdxT'(pendAddr);

    assign hit = isLoad && lineValid[reqIdx] && (lineAddr[reqIdx] == reqQ.addr);

    always_comb begin
        memReq       = reqQ;                        // Misses and stores go out unchanged.
        memReq.valid = reqQ.valid && !hit;
    end

    always_comb begin
        if (hit) begin
            portRsp.valid = 1'b1;
            portRsp.data  = lineData[reqIdx];
        end else begin
            portRsp = memRsp;                       // Memory answers pass straight back.
        end
    end

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reqQ    <= '0;
            pending <= 1'b0;
        end else begin
            reqQ <= portReq;
            if (memReq.valid) begin
                pending <= 1'b1;
            end else if (memRsp.valid) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq.valid) begin
            pendLoad <= !memReq.isWrite;
            pendAddr <= memReq.addr;
        end
    end

    // ====================
    // Fill and invalidate
    // ====================

    // A store may hit bytes cached under its own address, the one below
    // (whose high byte it overwrites) or, for halfwords, the one above.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lineValid <= '0;
        end else begin
            if (memRsp.valid && pendLoad) begin
                lineValid[fillIdx] <= 1'b1;
            end
            if (isStore) begin
                if (lineAddr[reqIdx] == reqQ.addr) lineValid[reqIdx] <= 1'b0;
                if (lineAddr[belowIdx] == belowAddr) lineValid[belowIdx] <= 1'b0;
                if (!reqQ.isByte && lineAddr[aboveIdx] == aboveAddr) begin
                    lineValid[aboveIdx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memRsp.valid && pendLoad) begin
            lineAddr[fillIdx] <= pendAddr;
            lineData[fillIdx] <= memRsp.data;
        end
    end

    // The memory only answers what this cache sent it.
    assert property (@(posedge clk) disable iff (!rstn) memRsp.valid |-> pending);

endmodule

`default_nettype wire

//--- hw/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  memReqT memReq,
    output memRspT memRsp
);

    logic [7:0] mem [MEM_BYTES];
    memReqT     pipe [MEM_LATENCY];      // Request delay line, stage 0 first.
    memReqT     tail;
    memAddrT    nextAddr;

    assign tail     = pipe[MEM_LATENCY-1];
    assign nextAddr = tail.addr + memAddrT'(1);  // Wraps at the top of memory.

    // ====================
    // Delay line
    // ====================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= memReq;           // Shifts every cycle, idle or not.
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // ====================
    // Byte array
    // ====================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (tail.valid && tail.isWrite) begin
            mem[tail.addr] <= tail.data[7:0];
            if (!tail.isByte) begin
                mem[nextAddr] <= tail.data[15:8];
            end
        end
    end

    // The response leaves in the same cycle the request reaches the last stage.
    always_comb begin
        memRsp.valid = tail.valid;
        memRsp.data  = '0;
        if (tail.valid && !tail.isWrite) begin
            memRsp.data = {mem[nextAddr], mem[tail.addr]};
        end
    end

    // Byte size only exists for stores; a byte load means the port built a bad request.
    assert property (@(posedge clk) disable iff (!rstn)
        tail.valid && tail.isByte |-> tail.isWrite);

endmodule

`default_nettype wire

//--- hw/memHierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module memHierarchy
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  busWordT               pwdata,
    input  logic [3:0]            pstrb,
    output busWordT               prdata,
    output logic                  pready,
    output logic                  pslverr
);

    memReqT portReq;   // Port to cache.
    memRspT portRsp;
    memReqT memReq;    // Cache to memory.
    memRspT memRsp;

    apbMemPort port (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .portReq(portReq), .portRsp(portRsp)
    );

    loadCache cache (
        .clk(clk), .rstn(rstn),
        .portReq(portReq), .portRsp(portRsp),
        .memReq(memReq), .memRsp(memRsp)
    );

    dataMemory memory (
        .clk(clk), .rstn(rstn),
        .memReq(memReq), .memRsp(memRsp)
    );

endmodule

`default_nettype wire

//--- verification/memHierarchyTb.sv
`timescale 1ns/1ps
`default_nettype none

module memHierarchyTb
    import memPkg::*;
();

    typedef logic [APB_ADDR_W-1:0] apbAddrT;

    logic       clk;
    logic       rstn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apbAddrT    paddr;
    busWordT    pwdata;
    logic [3:0] pstrb;
    busWordT    prdata;
    logic       pready;
    logic       pslverr;

    int         seed;
    int         dataErrors;
    int         flagErrors;
    int         latencyErrors;
    int         timeoutErrors;
    logic [7:0] model [MEM_BYTES];           // Reference copy of the data memory.

    memHierarchy uut (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    function automatic halfT modelLoad(input memAddrT a);
        memAddrT upper;
        upper = a + memAddrT'(1);            // The second byte wraps at the top of memory.
        return {model[upper], model[a]};
    endfunction

    task automatic modelStore(input memAddrT a, input halfT d, input logic isByte);
        memAddrT upper;
        upper = a + memAddrT'(1);
        model[a] = d[7:0];
        if (!isByte) model[upper] = d[15:8];
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Biased toward a small region so that loads hit and stores invalidate.
    function automatic memAddrT randAddr();
        int pick;
        pick = randBelow(8);
        if (pick == 0) return memAddrT'(MEM_BYTES - 1);
        if (pick < 5) return memAddrT'(randBelow(32));
        return memAddrT'(randBelow(MEM_BYTES));
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic checkHalf(input string name, input halfT exp, input halfT act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            dataErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected pslverr %b, actual %b", name, exp, act);
            flagErrors++;
        end
    endtask

    task automatic checkLatency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s: expected %0d cycles, actual %0d", name, exp, act);
            latencyErrors++;
        end
    endtask

    // ====================
    // APB driver
    // ====================

    // Counts access cycles before the one in which pready is seen high.
    task automatic apbTransfer(input logic write, input apbAddrT addr, input busWordT wdata,
                               input logic [3:0] strb, output busWordT rdata,
                               output logic err, output int cycles);
        @(negedge clk);
        psel    = 1'b1;                      // Setup phase.
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 0;
        rdata   = '0;
        err     = 1'b0;
        @(posedge clk);
        while (!pready && cycles < 40) begin
            cycles++;
            @(posedge clk);
        end
        if (pready) begin
            rdata = prdata;
            err   = pslverr;
        end else begin
            $display("Transfer at address %0d got no pready within 40 cycles", addr);
            timeoutErrors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input busWordT wdata, input logic [3:0] strb,
                            output logic err, output int cycles);
        busWordT unused;
        apbTransfer(1'b1, addr, wdata, strb, unused, err, cycles);
    endtask

    task automatic apbRead(input apbAddrT addr, output busWordT rdata, output logic err,
                           output int cycles);
        apbTransfer(1'b0, addr, busWordT'($random(seed)), 4'($random(seed)), rdata, err, cycles);
    endtask

    task automatic storeAndCheck(input string name, input memAddrT a, input halfT d,
                                 input logic isByte);
        logic err;
        int   cycles;
        apbWrite(apbAddrT'(a), busWordT'({16'($random(seed)), d}),
                 isByte ? STRB_BYTE : STRB_HALF, err, cycles);
        modelStore(a, d, isByte);
        checkFlag(name, 1'b0, err);
        checkLatency(name, MEM_LATENCY + 2, cycles);   // Stores always reach memory.
    endtask

    task automatic loadAndCheck(input string name, input memAddrT a, output int cycles);
        busWordT data;
        logic    err;
        apbRead(apbAddrT'(a), data, err, cycles);
        checkHalf(name, modelLoad(a), data[15:0]);
        checkHalf({name, " upper half"}, '0, data[31:16]);
        checkFlag(name, 1'b0, err);
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        int      cycles;
        logic    err;
        busWordT data;
        memAddrT a;
        apbAddrT bad;
        int      kind;
        seed          = 73;
        dataErrors    = 0;
        flagErrors    = 0;
        latencyErrors = 0;
        timeoutErrors = 0;
        model         = '{default: 8'h00};
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < 8; i++) begin
            loadAndCheck("cleared memory", memAddrT'(randBelow(MEM_BYTES)), cycles);
        end

        for (int i = 0; i < 300; i++) begin
            a    = randAddr();
            kind = randBelow(3);
            if (kind == 0) storeAndCheck("random byte store", a, halfT'($random(seed)), 1'b1);
            else if (kind == 1) storeAndCheck("random half store", a, halfT'($random(seed)), 1'b0);
            else loadAndCheck("random load", a, cycles);
        end

        a = memAddrT'(randBelow(MEM_BYTES));
        storeAndCheck("latency setup store", a, halfT'($random(seed)), 1'b0);
        loadAndCheck("latency first load", a, cycles);
        checkLatency("latency first load", MEM_LATENCY + 2, cycles);
        loadAndCheck("latency second load", a, cycles);
        checkLatency("latency second load", 2, cycles);

        a = memAddrT'(1 + randBelow(MEM_BYTES - 2));
        loadAndCheck("invalidate warm load", a, cycles);
        storeAndCheck("byte store above", a + memAddrT'(1), halfT'($random(seed)), 1'b1);
        loadAndCheck("reload after byte store", a, cycles);
        checkLatency("reload after byte store", MEM_LATENCY + 2, cycles);
        storeAndCheck("half store below", a - memAddrT'(1), halfT'($random(seed)), 1'b0);
        loadAndCheck("reload after half store", a, cycles);
        checkLatency("reload after half store", MEM_LATENCY + 2, cycles);

        bad = apbAddrT'(MEM_BYTES + randBelow(3072));   // Its low bits alias a real address.
        apbWrite(bad, busWordT'($random(seed)), STRB_HALF, err, cycles);
        checkFlag("write above range", 1'b1, err);
        checkLatency("write above range", 0, cycles);
        apbRead(apbAddrT'(MEM_BYTES + randBelow(3072)), data, err, cycles);
        checkFlag("read above range", 1'b1, err);
        checkLatency("read above range", 0, cycles);
        a = memAddrT'(randBelow(MEM_BYTES));
        apbWrite(apbAddrT'(a), busWordT'($random(seed)), 4'b0010, err, cycles);
        checkFlag("write with bad strobe", 1'b1, err);
        checkLatency("write with bad strobe", 0, cycles);
        loadAndCheck("unchanged after bad strobe", a, cycles);
        loadAndCheck("unchanged after bad address", memAddrT'(bad), cycles);

        $display("Errors: data %0d, flag %0d, latency %0d, timeout %0d",
                 dataErrors, flagErrors, latencyErrors, timeoutErrors);
        if (dataErrors + flagErrors + latencyErrors + timeoutErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- memHierarchy.f
hw/memPkg.sv
hw/apbMemPort.sv
hw/loadCache.sv
hw/dataMemory.sv
hw/memHierarchy.sv
verification/memHierarchyTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module memHierarchyTb -f memHierarchy.f
	./obj_dir/VmemHierarchyTb 2>&1 | tee sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
